/* logic/cachePkg.sv */
package cachePkg;

    // byte address and line geometry
    localparam int AddrWidth = 32;
    localparam int OffsetWidth = 4;
    localparam int SetWidth = 4;
    localparam int WayWidth = 2;

    // tag is what is left above set and offset
    localparam int TagWidth = AddrWidth - SetWidth - OffsetWidth;

    // 16 bytes per line, 128 bits
    localparam int LineBytes = 1 << OffsetWidth;
    localparam int LineWidth = LineBytes * 8;

    // bus moves half a line per beat
    localparam int BeatWidth = 64;

    localparam int WayCount = 1 << WayWidth;
    // 16 sets of 4 ways
    localparam int LineCount = WayCount << SetWidth;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [TagWidth-1:0] tagT;
    typedef logic [SetWidth-1:0] setT;
    typedef logic [WayWidth-1:0] wayT;
    typedef logic [LineWidth-1:0] lineT;
    typedef logic [BeatWidth-1:0] beatT;
    // one bit per data bit, set means write
    typedef logic [LineWidth-1:0] lineMaskT;
    // {set, way} row in the tag and data stores
    typedef logic [SetWidth+WayWidth-1:0] lineIndexT;

    // miss handling states
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } cacheStateT;

endpackage

/* logic/cacheController.sv */
module cacheController (
    input  logic                  clock,
    input  logic                  reset,
    // cpu request, held until rspDone
    input  logic                  reqValid,
    input  logic                  reqWrite,
    input  cachePkg::addrT        reqAddr,
    // tag store and victim
    input  logic                  hit,
    input  cachePkg::wayT         hitWay,
    input  cachePkg::wayT         victimWay,
    input  cachePkg::tagT         victimTag,
    input  logic                  victimDirty,
    // data path
    input  cachePkg::lineT        readLine,
    input  cachePkg::lineT        alignedData,
    input  cachePkg::lineMaskT    alignedMask,
    // bus inputs
    input  logic                  arReady,
    input  logic                  rValid,
    input  cachePkg::beatT        rData,
    input  logic                  rLast,
    input  logic                  awReady,
    input  logic                  wReady,
    output cachePkg::cacheStateT  state,
    output logic                  tagWrite,
    output logic                  validSet,
    output logic                  dirtySet,
    output logic                  dirtyClear,
    output cachePkg::lineIndexT   lineIndex,
    output logic                  lineWrite,
    output cachePkg::lineMaskT    lineMaskSelect,
    output cachePkg::lineT        lineWriteData,
    output logic                  captureVictim,
    output logic                  rspDone,
    // bus outputs
    output logic                  arValid,
    output cachePkg::addrT        arAddr,
    output logic                  rReady,
    output logic                  awValid,
    output cachePkg::addrT        awAddr,
    output logic                  wValid,
    output cachePkg::beatT        wData,
    output logic                  wLast
);
    import cachePkg::*;

    cacheStateT nextState;
    // 0 on the low half beat, 1 on the high half
    logic beat;
    setT reqSet;
    tagT reqTag;
    logic arFire;
    logic awFire;
    logic rFire;
    logic wFire;
    logic writeHit;

    assign reqSet = reqAddr[OffsetWidth +: SetWidth];
    assign reqTag = reqAddr[AddrWidth-1 -: TagWidth];

    assign arFire = arValid && arReady;
    assign awFire = awValid && awReady;
    assign rFire = rValid && rReady;
    assign wFire = wValid && wReady;
    assign writeHit = (state == lookup) && hit && reqWrite;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            beat <= 1'b0;
        end else begin
            state <= nextState;
            // toggles per accepted beat, back to 0 after a burst
            if (wFire || rFire) begin
                beat <= ~beat;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (reqValid) begin
                    nextState = lookup;
                end
            end
            lookup: begin
                nextState = hit ? idle : miss;
            end
            miss: begin
                // dirty victim goes out first, then the refill
                if (victimDirty) begin
                    if (awFire) begin
                        nextState = replace;
                    end
                end else if (arFire) begin
                    nextState = refill;
                end
            end
            replace: begin
                if (wFire && wLast) begin
                    nextState = miss;
                end
            end
            refill: begin
                // lookup again, now a hit
                if (rFire && rLast) begin
                    nextState = lookup;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // hit way while looking up, victim way through the miss
    assign lineIndex = (state == idle || state == lookup) ? {reqSet, hitWay}
                                                          : {reqSet, victimWay};

    // refill beat lands in its half, the mask picks which
    assign lineWrite = writeHit || rFire;
    assign lineWriteData = (state == refill) ? {rData, rData} : alignedData;
    always_comb begin
        if (state == refill) begin
            lineMaskSelect = beat ? {{BeatWidth{1'b1}}, {BeatWidth{1'b0}}}
                                  : {{BeatWidth{1'b0}}, {BeatWidth{1'b1}}};
        end else begin
            lineMaskSelect = alignedMask;
        end
    end

    // tag early so lookup sees it, valid once the line is whole
    assign tagWrite = rFire && !beat;
    assign validSet = rFire && rLast;
    assign dirtySet = writeHit;
    assign dirtyClear = wFire && wLast;

    assign captureVictim = (state == lookup) && !hit;
    assign rspDone = (state == lookup) && hit;

    // line-aligned burst addresses
    assign awValid = (state == miss) && victimDirty;
    assign awAddr = {victimTag, reqSet, {OffsetWidth{1'b0}}};
    assign arValid = (state == miss) && !victimDirty;
    assign arAddr = {reqTag, reqSet, {OffsetWidth{1'b0}}};

    // victim line already read out during miss
    assign wValid = (state == replace);
    assign wLast = (state == replace) && beat;
    assign wData = beat ? readLine[LineWidth-1:BeatWidth] : readLine[BeatWidth-1:0];

    assign rReady = (state == refill);

endmodule

/* logic/tagStore.sv */
module tagStore (
    input  logic             clock,
    input  logic             reset,
    input  cachePkg::setT    set,
    input  cachePkg::tagT    lookupTag,
    input  logic             tagWrite,
    input  cachePkg::wayT    writeWay,
    input  cachePkg::wayT    victimWay,
    input  logic             validSet,
    input  logic             dirtySet,
    input  logic             dirtyClear,
    output logic             hit,
    output cachePkg::wayT    hitWay,
    output cachePkg::tagT    victimTag,
    output logic             victimDirty
);
    import cachePkg::*;

    tagT tags [LineCount];
    logic [LineCount-1:0] validBits;
    logic [LineCount-1:0] dirtyBits;
    logic [WayCount-1:0] wayMatch;
    lineIndexT writeIndex;
    lineIndexT victimIndex;

    assign writeIndex = {set, writeWay};
    assign victimIndex = {set, victimWay};

    always_ff @(posedge clock) begin
        if (tagWrite) begin
            tags[writeIndex] <= lookupTag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (validSet) begin
                validBits[writeIndex] <= 1'b1;
            end
            // write hit marks, writeback done clears
            if (dirtySet) begin
                dirtyBits[writeIndex] <= 1'b1;
            end else if (dirtyClear) begin
                dirtyBits[writeIndex] <= 1'b0;
            end
        end
    end

    // compare all four ways of the set at once
    for (genvar w = 0; w < WayCount; w++) begin : gWayMatch
        assign wayMatch[w] = validBits[{set, wayT'(w)}]
                          && (tags[{set, wayT'(w)}] == lookupTag);
    end

    assign hit = |wayMatch;

    // highest matching way wins
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < WayCount; w++) begin
            if (wayMatch[w]) begin
                hitWay = wayT'(w);
            end
        end
    end

    assign victimTag = tags[victimIndex];
    assign victimDirty = validBits[victimIndex] && dirtyBits[victimIndex];

endmodule

/* logic/dataArray.sv */
module dataArray (
    input  logic                 clock,
    input  cachePkg::lineIndexT  index,
    input  logic                 write,
    input  cachePkg::lineMaskT   mask,
    input  cachePkg::lineT       writeData,
    output cachePkg::lineT       readData
);
    import cachePkg::*;

    lineT mem [LineCount];
    lineT mergedLine;

    // keep old bits where the mask is clear
    assign mergedLine = (mem[index] & ~mask) | (writeData & mask);

    always_ff @(posedge clock) begin
        if (write) begin
            mem[index] <= mergedLine;
        end
    end

    // registered read, sees the write of the same edge
    always_ff @(posedge clock) begin
        if (write) begin
            readData <= mergedLine;
        end else begin
            readData <= mem[index];
        end
    end

endmodule

/* logic/lineAligner.sv */
module lineAligner (
    input  logic [3:0]          offset,
    input  logic [7:0]          reqMask,
    input  cachePkg::beatT      reqWdata,
    input  cachePkg::lineT      readLine,
    output cachePkg::lineT      alignedData,
    output cachePkg::lineMaskT  alignedMask,
    output cachePkg::beatT      rspData
);
    import cachePkg::*;

    // byte offset as a bit shift
    logic [OffsetWidth+2:0] bitShift;
    beatT beatMask;
    lineT shiftedLine;

    assign bitShift = {offset, 3'b000};

    // only 1, 2, 4 and 8 byte accesses write
    always_comb begin
        case (reqMask)
            8'h01: begin
                beatMask = 64'h0000_0000_0000_00ff;
            end
            8'h03: begin
                beatMask = 64'h0000_0000_0000_ffff;
            end
            8'h0f: begin
                beatMask = 64'h0000_0000_ffff_ffff;
            end
            8'hff: begin
                beatMask = '1;
            end
            default: begin
                beatMask = '0;
            end
        endcase
    end

    // bytes past the line end fall off
    assign alignedData = {{BeatWidth{1'b0}}, reqWdata} << bitShift;
    assign alignedMask = {{BeatWidth{1'b0}}, beatMask} << bitShift;

    // low beat of the line from the offset up
    assign shiftedLine = readLine >> bitShift;
    assign rspData = shiftedLine[BeatWidth-1:0];

endmodule

/* logic/replacementLfsr.sv */
module replacementLfsr (
    input  logic           clock,
    input  logic           reset,
    input  logic           capture,
    output cachePkg::wayT  victimWay
);
    import cachePkg::*;

    logic [15:0] lfsr;

    // taps 0, 2, 3, 5, shifting right
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= 16'h0001;
        end else begin
            lfsr <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        end
    end

    // held for the whole miss
    always_ff @(posedge clock) begin
        if (reset) begin
            victimWay <= '0;
        end else if (capture) begin
            victimWay <= lfsr[WayWidth-1:0];
        end
    end

endmodule

/* logic/cacheTop.sv */
module cacheTop (
    input  logic              clock,
    input  logic              reset,
    // cpu load/store port
    input  logic              reqValid,
    input  logic              reqWrite,
    input  cachePkg::addrT    reqAddr,
    input  cachePkg::beatT    reqWdata,
    input  logic [7:0]        reqMask,
    output cachePkg::beatT    rspData,
    output logic              rspDone,
    // memory read channel
    output logic              arValid,
    output cachePkg::addrT    arAddr,
    input  logic              arReady,
    input  logic              rValid,
    input  cachePkg::beatT    rData,
    input  logic              rLast,
    output logic              rReady,
    // memory write channel
    output logic              awValid,
    output cachePkg::addrT    awAddr,
    input  logic              awReady,
    output logic              wValid,
    output cachePkg::beatT    wData,
    output logic              wLast,
    input  logic              wReady
);
    import cachePkg::*;

    // request address split
    setT reqSet;
    tagT reqTag;
    logic [OffsetWidth-1:0] reqOffset;

    // tag store results
    logic hit;
    wayT hitWay;
    tagT victimTag;
    logic victimDirty;
    wayT victimWay;

    // controller outputs
    cacheStateT state;
    logic tagWrite;
    logic validSet;
    logic dirtySet;
    logic dirtyClear;
    logic captureVictim;
    lineIndexT lineIndex;
    logic lineWrite;
    lineMaskT lineMaskSelect;
    lineT lineWriteData;

    // data path
    lineT readLine;
    lineT alignedData;
    lineMaskT alignedMask;

    assign reqOffset = reqAddr[OffsetWidth-1:0];
    assign reqSet = reqAddr[OffsetWidth +: SetWidth];
    assign reqTag = reqAddr[AddrWidth-1 -: TagWidth];

    cacheController controller (
        .clock(clock), .reset(reset),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr),
        .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
        .victimTag(victimTag), .victimDirty(victimDirty),
        .readLine(readLine), .alignedData(alignedData), .alignedMask(alignedMask),
        .arReady(arReady), .rValid(rValid), .rData(rData), .rLast(rLast),
        .awReady(awReady), .wReady(wReady),
        .state(state), .tagWrite(tagWrite), .validSet(validSet),
        .dirtySet(dirtySet), .dirtyClear(dirtyClear),
        .lineIndex(lineIndex), .lineWrite(lineWrite),
        .lineMaskSelect(lineMaskSelect), .lineWriteData(lineWriteData),
        .captureVictim(captureVictim), .rspDone(rspDone),
        .arValid(arValid), .arAddr(arAddr), .rReady(rReady),
        .awValid(awValid), .awAddr(awAddr),
        .wValid(wValid), .wData(wData), .wLast(wLast)
    );

    // the way field of the line index is the way being updated
    tagStore tags (
        .clock(clock), .reset(reset),
        .set(reqSet), .lookupTag(reqTag),
        .tagWrite(tagWrite), .writeWay(lineIndex[WayWidth-1:0]),
        .victimWay(victimWay),
        .validSet(validSet), .dirtySet(dirtySet), .dirtyClear(dirtyClear),
        .hit(hit), .hitWay(hitWay),
        .victimTag(victimTag), .victimDirty(victimDirty)
    );

    dataArray lines (
        .clock(clock), .index(lineIndex), .write(lineWrite),
        .mask(lineMaskSelect), .writeData(lineWriteData),
        .readData(readLine)
    );

    lineAligner aligner (
        .offset(reqOffset), .reqMask(reqMask), .reqWdata(reqWdata),
        .readLine(readLine), .alignedData(alignedData),
        .alignedMask(alignedMask), .rspData(rspData)
    );

    replacementLfsr lfsr (
        .clock(clock), .reset(reset),
        .capture(captureVictim), .victimWay(victimWay)
    );

endmodule

/* test/burstMemory.sv */
module burstMemory (
    input  logic            clock,
    input  logic            reset,
    // read channel
    input  logic            arValid,
    input  cachePkg::addrT  arAddr,
    output logic            arReady,
    output logic            rValid,
    output cachePkg::beatT  rData,
    output logic            rLast,
    input  logic            rReady,
    // write channel
    input  logic            awValid,
    input  cachePkg::addrT  awAddr,
    output logic            awReady,
    input  logic            wValid,
    input  cachePkg::beatT  wData,
    input  logic            wLast,
    output logic            wReady
);
    // 4 KiB, upper address bits ignored
    logic [7:0] mem [4096];
    logic [11:0] readBase;
    logic [11:0] writeBase;
    logic readBusy;
    logic writeBusy;
    logic readBeat;
    logic writeBeat;

    // start contents from address xor A5, upper nibble folded in
    initial begin
        for (int a = 0; a < 4096; a++) begin
            mem[a] = 8'(a) ^ {4'h0, 4'(a >> 8)} ^ 8'hA5;
        end
    end

    // one burst at a time, either direction
    assign arReady = !readBusy && !writeBusy;
    assign awReady = !readBusy && !writeBusy && !arValid;
    assign rValid = readBusy;
    assign rLast = readBusy && readBeat;
    assign wReady = writeBusy;

    // low half first, then high half
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rData[8*i +: 8] = mem[readBase + {8'h0, readBeat, 3'b000} + 12'(i)];
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            readBusy <= 1'b0;
            writeBusy <= 1'b0;
            readBeat <= 1'b0;
            writeBeat <= 1'b0;
            readBase <= '0;
            writeBase <= '0;
        end else begin
            if (arValid && arReady) begin
                readBusy <= 1'b1;
                readBeat <= 1'b0;
                readBase <= arAddr[11:0];
            end else if (rValid && rReady) begin
                readBeat <= ~readBeat;
                if (readBeat) begin
                    readBusy <= 1'b0;
                end
            end
            if (awValid && awReady) begin
                writeBusy <= 1'b1;
                writeBeat <= 1'b0;
                writeBase <= awAddr[11:0];
            end else if (wValid && wReady) begin
                for (int i = 0; i < 8; i++) begin
                    mem[writeBase + {8'h0, writeBeat, 3'b000} + 12'(i)] <= wData[8*i +: 8];
                end
                writeBeat <= ~writeBeat;
                if (writeBeat) begin
                    writeBusy <= 1'b0;
                end
            end
        end
    end

endmodule

/* test/cacheBus_properties.sv */
module cacheBus_properties (
    input  logic                  clock,
    input  logic                  reset,
    input  cachePkg::cacheStateT  state,
    input  logic                  arValid,
    input  logic                  arReady,
    input  cachePkg::addrT        arAddr,
    input  logic                  awValid,
    input  logic                  awReady,
    input  cachePkg::addrT        awAddr,
    input  logic                  wValid,
    input  logic                  wReady,
    input  logic                  wLast
);
    import cachePkg::*;

    // burst addresses on line boundaries
    arAligned: assert property (@(posedge clock) disable iff (reset)
        arValid |-> arAddr[OffsetWidth-1:0] == '0)
        else $error("arAddr not line-aligned");
    awAligned: assert property (@(posedge clock) disable iff (reset)
        awValid |-> awAddr[OffsetWidth-1:0] == '0)
        else $error("awAddr not line-aligned");

    lastWithValid: assert property (@(posedge clock) disable iff (reset)
        wLast |-> wValid)
        else $error("wLast without wValid");

    // one direction at a time
    noDualRequest: assert property (@(posedge clock) disable iff (reset)
        !(arValid && awValid))
        else $error("arValid and awValid together");

    // held until accepted, address stable
    arHeld: assert property (@(posedge clock) disable iff (reset)
        arValid && !arReady |=> arValid && $stable(arAddr))
        else $error("arValid dropped before arReady");
    awHeld: assert property (@(posedge clock) disable iff (reset)
        awValid && !awReady |=> awValid && $stable(awAddr))
        else $error("awValid dropped before awReady");
    wHeld: assert property (@(posedge clock) disable iff (reset)
        wValid && !wReady |=> wValid)
        else $error("wValid dropped before wReady");

    // writeback opens on its low half beat
    wFirstBeat: assert property (@(posedge clock) disable iff (reset)
        state == replace && $past(state) != replace |-> !wLast)
        else $error("wLast on the first writeback beat");

endmodule

bind cacheTop cacheBus_properties busProps (.*);

/* test/cacheTb.sv */
module cacheTb;
    import cachePkg::*;

    // 26 accesses of under 20 cycles each, wide margin
    localparam int CycleLimit = 4000;

    logic clock;
    logic reset;
    logic reqValid;
    logic reqWrite;
    addrT reqAddr;
    beatT reqWdata;
    logic [7:0] reqMask;
    beatT rspData;
    logic rspDone;
    logic arValid;
    addrT arAddr;
    logic arReady;
    logic rValid;
    beatT rData;
    logic rLast;
    logic rReady;
    logic awValid;
    addrT awAddr;
    logic awReady;
    logic wValid;
    beatT wData;
    logic wLast;
    logic wReady;

    // what memory would hold if the cache were write-through
    logic [7:0] shadow [4096];
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    addrT missAddr;

    cacheTop UUT (.*);
    burstMemory memory (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] patternByte(input logic [11:0] a);
        return a[7:0] ^ {4'h0, a[11:8]} ^ 8'hA5;
    endfunction

    task automatic checkValue(input string name, input beatT expected, input beatT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    // bytes of the access, cut at the line end
    task automatic writeShadow(input addrT addr, input beatT data, input logic [7:0] mask);
        int count;
        count = (mask == 8'h01) ? 1 : (mask == 8'h03) ? 2 : (mask == 8'h0f) ? 4 :
                (mask == 8'hff) ? 8 : 0;
        for (int i = 0; i < count; i++) begin
            if (int'(addr[3:0]) + i < 16) begin
                shadow[addr[11:0] + 12'(i)] = data[8*i +: 8];
            end
        end
    endtask

    // bytes past the line end read as zero
    function automatic beatT expectedRead(input addrT addr);
        beatT r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            if (int'(addr[3:0]) + i < 16) begin
                r[8*i +: 8] = shadow[addr[11:0] + 12'(i)];
            end
        end
        return r;
    endfunction

    // one request, held until rspDone, dropped the cycle after
    task automatic access(input logic write, input addrT addr, input beatT data,
                          input logic [7:0] mask, output beatT result,
                          output int latency, output logic busUsed);
        @(posedge clock);
        #1;
        reqValid = 1'b1;
        reqWrite = write;
        reqAddr = addr;
        reqWdata = data;
        reqMask = mask;
        latency = 0;
        busUsed = 1'b0;
        // idle cycle that takes the request, latency counts after it
        @(negedge clock);
        while (!rspDone) begin
            @(negedge clock);
            latency++;
            if (arValid || awValid) begin
                busUsed = 1'b1;
            end
        end
        result = rspData;
        @(posedge clock);
        #1;
        reqValid = 1'b0;
        if (write) begin
            writeShadow(addr, data, mask);
        end
    endtask

    task automatic readCheck(input addrT addr);
        beatT result;
        int latency;
        logic busUsed;
        access(1'b0, addr, '0, 8'hff, result, latency, busUsed);
        checkValue("rspData", expectedRead(addr), result);
    endtask

    task automatic resetTest();
        repeat (4) begin
            @(negedge clock);
            checkValue("rspDone", '0, beatT'(rspDone));
            checkValue("arValid", '0, beatT'(arValid));
            checkValue("awValid", '0, beatT'(awValid));
            checkValue("wValid", '0, beatT'(wValid));
            checkValue("rReady", '0, beatT'(rReady));
        end
    endtask

    task automatic readMissTest();
        beatT result;
        int latency;
        logic busUsed;
        // low half of the address space, doubleword aligned
        missAddr = {20'h0, 12'($urandom) & 12'h7f8};
        access(1'b0, missAddr, '0, 8'hff, result, latency, busUsed);
        checkValue("rspData", expectedRead(missAddr), result);
        if (!busUsed) begin
            errorCount++;
            $display("read miss completed without any bus read");
        end
    endtask

    task automatic hitLatencyTest();
        beatT result;
        int latency;
        logic busUsed;
        access(1'b0, missAddr, '0, 8'hff, result, latency, busUsed);
        checkValue("rspData", expectedRead(missAddr), result);
        checkValue("hit latency", 64'd1, beatT'(latency));
        if (busUsed) begin
            errorCount++;
            $display("repeat read of a cached line used the bus");
        end
    endtask

    task automatic writeReadTest();
        logic [7:0] masks [4];
        int offsets [4];
        addrT base;
        addrT addr;
        beatT result;
        int latency;
        logic busUsed;
        masks = '{8'h01, 8'h03, 8'h0f, 8'hff};
        offsets = '{5, 10, 4, 8};
        // tags 8 and up, clear of the eviction lines
        base = {20'h0, 12'h800 | (12'($urandom) & 12'h7f0)};
        for (int k = 0; k < 4; k++) begin
            addr = base + addrT'(offsets[k]);
            access(1'b1, addr, {$urandom, $urandom}, masks[k], result, latency, busUsed);
            readCheck({addr[31:3], 3'b000});
        end
        readCheck(base);
    endtask

    task automatic evictionTest();
        addrT addr;
        beatT result;
        int latency;
        logic busUsed;
        int evicted;
        logic matchShadow;
        logic matchPattern;
        logic [11:0] a;
        evicted = 0;
        // five tags into set 9, one more than the ways
        for (int t = 1; t <= 5; t++) begin
            addr = addrT'((t << 8) | (9 << 4));
            access(1'b1, addr, {$urandom, $urandom}, 8'hff, result, latency, busUsed);
        end
        for (int t = 1; t <= 5; t++) begin
            readCheck(addrT'((t << 8) | (9 << 4)));
            readCheck(addrT'((t << 8) | (9 << 4) | 8));
        end
        // an evicted line holds the shadow, a resident one the start pattern
        for (int t = 1; t <= 5; t++) begin
            matchShadow = 1'b1;
            matchPattern = 1'b1;
            for (int i = 0; i < 16; i++) begin
                a = 12'((t << 8) | (9 << 4) | i);
                if (memory.mem[a] !== shadow[a]) begin
                    matchShadow = 1'b0;
                end
                if (memory.mem[a] !== patternByte(a)) begin
                    matchPattern = 1'b0;
                end
            end
            checkCount++;
            if (matchShadow) begin
                evicted++;
            end else if (!matchPattern) begin
                errorCount++;
                $display("memory line at 0x%h holds neither written nor original data",
                         (t << 8) | (9 << 4));
            end
        end
        checkCount++;
        if (evicted == 0) begin
            errorCount++;
            $display("no dirty line of the full set was written back");
        end
    endtask

    initial begin
        void'($urandom(65));
        for (int a = 0; a < 4096; a++) begin
            shadow[a] = patternByte(12'(a));
        end
        reset = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqWdata = '0;
        reqMask = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        resetTest();
        readMissTest();
        hitLatencyTest();
        writeReadTest();
        evictionTest();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
logic/cachePkg.sv
logic/cacheController.sv
logic/tagStore.sv
logic/dataArray.sv
logic/lineAligner.sv
logic/replacementLfsr.sv
logic/cacheTop.sv
test/burstMemory.sv
test/cacheBus_properties.sv
test/cacheTb.sv

/* Makefile */
# cache testbench under Verilator

SIMLOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module cacheTb -Mdir obj_dir

run: compile
	./obj_dir/VcacheTb 2>&1 | tee $(SIMLOG)
	grep -q "Simulation finished: PASS" $(SIMLOG)

clean:
	rm -rf obj_dir $(SIMLOG)
